// File: include/retry_cfg.svh
`ifndef RETRY_CFG_SVH
`define RETRY_CFG_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Width of both operands and of the computed result
`define RETRY_DATA_W 16

// Width of the user tag that travels with every request
`define RETRY_TAG_W 8

//////////////////////////////
// Pipeline and ID space
//////////////////////////////

// Register stages between retry_start and retry_end
`define RETRY_PIPE_DEPTH 3

// ID width is clog2 of the pipe depth plus one, so eight storage slots
`define RETRY_ID_W 3

`endif

// File: hdl/retry_pkg.sv
`include "retry_cfg.svh"

package retry_pkg;

    //////////////////////////////
    // Opcodes
    //////////////////////////////

    // Arithmetic operations the checked pipe can apply
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_AND = 2'd3
    } op_e;

    // Sequence ID handed out by retry_start
    typedef logic [`RETRY_ID_W-1:0] id_t;

    //////////////////////////////
    // Link payloads
    //////////////////////////////

    // One arithmetic request, 42 bits
    typedef struct packed {
        op_e                     op;
        logic [`RETRY_DATA_W-1:0] a;
        logic [`RETRY_DATA_W-1:0] b;
        logic [`RETRY_TAG_W-1:0]  tag;
    } op_req_t;

    // Result as seen by the consumer, tag first so it can sort
    typedef struct packed {
        logic [`RETRY_TAG_W-1:0]  tag;
        logic [`RETRY_DATA_W-1:0] result;
    } op_res_t;

    // Replay request sent from retry_end back to retry_start
    typedef struct packed {
        logic valid;
        id_t  id;
    } retry_req_t;

endpackage

// File: hdl/retry_start.sv
`include "retry_cfg.svh"

module retry_start import retry_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Upstream requests
    input  op_req_t    req_i,
    input  logic       valid_i,
    output logic       ready_o,

    // Towards the checked pipe
    output op_req_t    req_o,
    output id_t        id_o,
    output logic       valid_o,
    input  logic       ready_i,

    // Replay requests from retry_end
    input  retry_req_t retry_i,
    output logic       retry_ready_o
);

    // One storage slot per ID value
    localparam int SLOTS = 2 ** `RETRY_ID_W;

    //////////////////////////////
    // Pending replay
    //////////////////////////////

    logic failed_valid_q;
    logic failed_valid_d;
    id_t  failed_id_q;
    logic retry_take;
    logic xfer;

    // A retry is taken when both sides of the retry link agree
    assign retry_take = retry_i.valid & retry_ready_o;

    // Any item leaving towards the pipe, replayed or new
    assign xfer = valid_o & ready_i;

    // An offered retry means the pipe tail moves on in this cycle, so the
    // pipe is ready as well and a pending replay leaves at the same edge
    assign retry_ready_o = ~failed_valid_q | retry_i.valid;

    // The replay stays pending until the pipe accepts it
    assign failed_valid_d = retry_take | (failed_valid_q & ~ready_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            failed_valid_q <= 1'b0;
            failed_id_q    <= '0;
        end else begin
            failed_valid_q <= failed_valid_d;
            if (retry_take) begin
                failed_id_q <= retry_i.id;
            end
        end
    end

    //////////////////////////////
    // ID counter
    //////////////////////////////

    id_t cnt_q;

    // Every transfer gets a fresh ID, replays included
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (xfer) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign id_o = cnt_q;

    //////////////////////////////
    // Request storage
    //////////////////////////////

    op_req_t mem_q [SLOTS];

    // Whatever is sent is kept under the ID it was sent with
    always_ff @(posedge clk_i) begin
        if (xfer) begin
            mem_q[cnt_q] <= req_o;
        end
    end

    // A pending replay wins over new input and keeps its data stable
    assign req_o = failed_valid_q ? mem_q[failed_id_q] : req_i;

    //////////////////////////////
    // Handshake
    //////////////////////////////

    assign valid_o = valid_i | failed_valid_q;
    assign ready_o = ready_i & ~failed_valid_q;

    // The ID space must cover the pipe, so a retried ID is never the slot being written
    // The stored copy would otherwise be lost before its replay
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (retry_take && xfer) |-> (retry_i.id != cnt_q))
        else $error("retry_start: retried ID collides with the slot being written");

    // A new retry on top of a pending one only arrives while the pipe moves
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (retry_take && failed_valid_q) |-> ready_i)
        else $error("retry_start: retry overwrote a pending replay");

endmodule

// File: hdl/checked_pipe.sv
`include "retry_cfg.svh"

module checked_pipe import retry_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,

    // Requests from retry_start
    input  op_req_t req_i,
    input  id_t     id_i,
    input  logic    valid_i,
    output logic    ready_o,

    // Transient upset on the primary copy
    input  logic    fault_i,

    // Both results towards retry_end
    output op_res_t res_o,
    output op_res_t shadow_o,
    output id_t     id_o,
    output logic    valid_o,
    input  logic    ready_i
);

    localparam int DEPTH = `RETRY_PIPE_DEPTH;

    // Contents of one stage, both copies and the ID together
    typedef struct packed {
        op_req_t pri;
        op_req_t shd;
        id_t     id;
    } stage_t;

    // Applies the opcode of one copy and keeps its tag
    function automatic op_res_t apply_op(op_req_t r);
        op_res_t res;
        res.tag = r.tag;
        unique case (r.op)
            OP_ADD:  res.result = r.a + r.b;
            OP_SUB:  res.result = r.a - r.b;
            OP_XOR:  res.result = r.a ^ r.b;
            OP_AND:  res.result = r.a & r.b;
            default: res.result = '0;
        endcase
        return res;
    endfunction

    //////////////////////////////
    // Stage input
    //////////////////////////////

    stage_t stg_in;

    // The upset only touches the primary copy, the shadow stays clean
    always_comb begin
        stg_in       = '{pri: req_i, shd: req_i, id: id_i};
        stg_in.pri.a = {req_i.a[`RETRY_DATA_W-1:1], req_i.a[0] ^ fault_i};
    end

    //////////////////////////////
    // Stage registers
    //////////////////////////////

    logic   [DEPTH-1:0] vld_q;
    stage_t [DEPTH-1:0] stg_q;

    // The whole pipe moves as one, or holds while downstream stalls
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else if (ready_i) begin
            vld_q <= {vld_q[DEPTH-2:0], valid_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (ready_i) begin
            stg_q[0] <= stg_in;
            for (int i = 1; i < DEPTH; i++) begin
                stg_q[i] <= stg_q[i-1];
            end
        end
    end

    // Both copies are evaluated on the last stage
    assign res_o    = apply_op(stg_q[DEPTH-1].pri);
    assign shadow_o = apply_op(stg_q[DEPTH-1].shd);
    assign id_o     = stg_q[DEPTH-1].id;
    assign valid_o  = vld_q[DEPTH-1];
    assign ready_o  = ready_i;

    // Occupied stages keep their contents across a stall
    for (genvar g = 0; g < DEPTH; g++) begin : gen_hold_chk
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            (vld_q[g] && !ready_i) |=> (vld_q[g] && $stable(stg_q[g])))
            else $error("checked_pipe: stage %0d changed while stalled", g);
    end

endmodule

// File: hdl/retry_end.sv
`include "retry_cfg.svh"

module retry_end import retry_pkg::*; (
    // Results from the checked pipe
    input  op_res_t    res_i,
    input  op_res_t    shadow_i,
    input  id_t        id_i,
    input  logic       valid_i,
    output logic       ready_o,

    // Good results to the consumer
    output op_res_t    res_o,
    output logic       valid_o,
    input  logic       ready_i,

    // Replay path back to retry_start
    output retry_req_t retry_o,
    input  logic       retry_ready_i
);

    //////////////////////////////
    // Compare
    //////////////////////////////

    logic mismatch;
    logic faulty;

    // Primary and shadow must agree on tag and result
    assign mismatch = (res_i != shadow_i);

    // Only a real item can be faulty, an empty tail never asks for a replay
    assign faulty = valid_i & mismatch;

    //////////////////////////////
    // Steer
    //////////////////////////////

    // Faulty items go back by ID and never show up on res_o
    assign retry_o.valid = faulty;
    assign retry_o.id    = id_i;

    assign res_o   = res_i;
    assign valid_o = valid_i & ~mismatch;

    // The pipe tail is released by whichever side takes the item
    assign ready_o = faulty ? retry_ready_i : ready_i;

    // A result goes either downstream or back, never both
    always_comb begin
        assert (!(valid_o && retry_o.valid))
            else $error("retry_end: result both forwarded and retried");
    end

endmodule

// File: hdl/retry_top.sv
`include "retry_cfg.svh"

module retry_top import retry_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,

    // Upstream requests
    input  op_req_t req_i,
    input  logic    valid_i,
    output logic    ready_o,

    // Transient upset for the pipe input
    input  logic    fault_i,

    // Checked results, possibly out of order
    output op_res_t res_o,
    output logic    valid_o,
    input  logic    ready_i
);

    //////////////////////////////
    // Internal links
    //////////////////////////////

    // retry_start to checked_pipe
    op_req_t    s_req;
    id_t        s_id;
    logic       s_valid;
    logic       s_ready;

    // checked_pipe to retry_end
    op_res_t    p_res;
    op_res_t    p_shadow;
    id_t        p_id;
    logic       p_valid;
    logic       p_ready;

    // retry_end back to retry_start
    retry_req_t retry;
    logic       retry_ready;

    retry_start u_start (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req_i),
        .valid_i       (valid_i),
        .ready_o       (ready_o),
        .req_o         (s_req),
        .id_o          (s_id),
        .valid_o       (s_valid),
        .ready_i       (s_ready),
        .retry_i       (retry),
        .retry_ready_o (retry_ready)
    );

    checked_pipe u_pipe (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (s_req),
        .id_i     (s_id),
        .valid_i  (s_valid),
        .ready_o  (s_ready),
        .fault_i  (fault_i),
        .res_o    (p_res),
        .shadow_o (p_shadow),
        .id_o     (p_id),
        .valid_o  (p_valid),
        .ready_i  (p_ready)
    );

    retry_end u_end (
        .res_i         (p_res),
        .shadow_i      (p_shadow),
        .id_i          (p_id),
        .valid_i       (p_valid),
        .ready_o       (p_ready),
        .res_o         (res_o),
        .valid_o       (valid_o),
        .ready_i       (ready_i),
        .retry_o       (retry),
        .retry_ready_i (retry_ready)
    );

endmodule

// File: tb/retry_tb.sv
`include "retry_cfg.svh"

module retry_tb import retry_pkg::*; ;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED        = 70054;
    localparam int DEPTH       = `RETRY_PIPE_DEPTH;
    localparam int TAGS        = 2 ** `RETRY_TAG_W;
    localparam int N_PLAIN     = 40;
    localparam int N_STRESS    = 200;
    localparam int N_REQ       = N_PLAIN + N_STRESS;
    localparam int DRAIN_LIMIT = 20 * DEPTH;

    logic    clk;
    logic    rst_n;
    op_req_t req;
    logic    valid_i;
    logic    ready_o;
    logic    fault;
    op_res_t res;
    logic    valid_o;
    logic    ready_i;

    // Reference model, one entry per tag
    logic [`RETRY_DATA_W-1:0] exp_res [TAGS];
    int      acc_cycle [TAGS];
    int      recv_cnt [TAGS];

    int      next_tag;
    int      recv_total;
    int      cycle_cnt;
    int      mismatch_cnt;
    int      fail_cnt;
    bit      check_latency;
    bit      in_taken;
    bit      held;
    op_res_t held_res;

    retry_top dut (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .fault_i (fault),
        .res_o   (res),
        .valid_o (valid_o),
        .ready_i (ready_i)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Rising edges seen so far, so that latency can be measured in cycles
    always @(posedge clk) begin
        cycle_cnt++;
    end

    // Opcode rule of the datapath
    function automatic logic [`RETRY_DATA_W-1:0] model_result(op_e op,
            logic [`RETRY_DATA_W-1:0] a, logic [`RETRY_DATA_W-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            default: return a & b;
        endcase
    endfunction

    // Builds a fresh random request under the next unused tag
    task automatic make_request();
        logic [31:0] rnd;
        rnd     = $urandom;
        req.op  = op_e'(rnd[1:0]);
        req.tag = next_tag[`RETRY_TAG_W-1:0];
        rnd     = $urandom;
        req.a   = rnd[`RETRY_DATA_W-1:0];
        req.b   = rnd[31:32-`RETRY_DATA_W];
        exp_res[next_tag] = model_result(req.op, req.a, req.b);
        next_tag++;
    endtask

    task automatic check_result(op_res_t r);
        int t;
        t = int'(r.tag);
        if (t >= next_tag) begin
            fail_cnt++;
            $display("Result arrived with tag %0d which was never issued", t);
        end else if (recv_cnt[t] != 0) begin
            fail_cnt++;
            $display("Tag %0d was delivered more than once", t);
        end else begin
            if (r.result !== exp_res[t]) begin
                mismatch_cnt++;
                $display("MISMATCH res_o tag %02h expected %04h observed %04h",
                         r.tag, exp_res[t], r.result);
            end
            if (check_latency && (cycle_cnt - acc_cycle[t] != DEPTH)) begin
                fail_cnt++;
                $display("Tag %0d came back after %0d cycles instead of %0d",
                         t, cycle_cnt - acc_cycle[t], DEPTH);
            end
            recv_total++;
        end
        recv_cnt[t]++;
    endtask

    //////////////////////////////
    // Monitor
    //////////////////////////////

    // Sampled mid cycle, where inputs and outputs have long settled
    always @(negedge clk) begin
        if (!rst_n) begin
            in_taken = 1'b0;
            held     = 1'b0;
        end else begin
            // A handshake seen here completes on the next rising edge
            if (valid_i && ready_o) begin
                acc_cycle[req.tag] = cycle_cnt;
            end
            in_taken = valid_i && ready_o;
            if (valid_o && ready_i) begin
                check_result(res);
            end
            // A stalled result must stay put until it is taken
            if (held && !valid_o) begin
                fail_cnt++;
                $display("valid_o dropped while the consumer was stalling");
            end else if (held && res !== held_res) begin
                mismatch_cnt++;
                $display("MISMATCH res_o changed under stall expected %06h observed %06h",
                         held_res, res);
            end
            held     = valid_o && !ready_i;
            held_res = res;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Stress mode adds input gaps, random upsets and consumer stalls
    task automatic run_phase(input int count, input bit stress);
        int sent;
        sent = 0;
        while (sent < count || valid_i) begin
            @(posedge clk);
            #1;
            if (valid_i && in_taken) begin
                valid_i = 1'b0;
            end
            if (!valid_i && sent < count && (!stress || $urandom_range(3) != 0)) begin
                make_request();
                valid_i = 1'b1;
                sent++;
            end
            fault   = stress && ($urandom_range(7) == 0);
            ready_i = !stress || ($urandom_range(3) != 0);
        end
    endtask

    // Waits until every issued tag is back or the drain limit runs out
    task automatic drain_results();
        int waited;
        fault   = 1'b0;
        ready_i = 1'b1;
        waited  = 0;
        while (recv_total < next_tag && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic check_all_returned();
        for (int t = 0; t < next_tag; t++) begin
            if (recv_cnt[t] == 0) begin
                fail_cnt++;
                $display("Tag %0d was issued but never returned", t);
            end
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        req           = '0;
        valid_i       = 1'b0;
        fault         = 1'b0;
        ready_i       = 1'b1;
        next_tag      = 0;
        recv_total    = 0;
        cycle_cnt     = 0;
        mismatch_cnt  = 0;
        fail_cnt      = 0;
        check_latency = 1'b1;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (!ready_o) begin
            fail_cnt++;
            $display("ready_o is low right after reset");
        end
        if (valid_o) begin
            fail_cnt++;
            $display("valid_o is high right after reset");
        end
        // Clean back-to-back traffic first, where latency is fixed
        run_phase(N_PLAIN, 1'b0);
        drain_results();
        check_latency = 1'b0;
        run_phase(N_STRESS, 1'b1);
        drain_results();
        check_all_returned();
        $display("Results %0d of %0d, mismatches %0d, other errors %0d",
                 recv_total, next_tag, mismatch_cnt, fail_cnt);
        if (mismatch_cnt + fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Forty cycles per request leaves ample room for long retry chains under back-pressure
    initial begin
        #(N_REQ * 40 * 8);
        $display("Timeout after %0d ns with %0d of %0d results received",
                 N_REQ * 40 * 8, recv_total, next_tag);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: retry_top.f
+incdir+include
hdl/retry_pkg.sv
hdl/retry_start.sv
hdl/checked_pipe.sv
hdl/retry_end.sv
hdl/retry_top.sv
tb/retry_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the retry testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module retry_tb \
    -f retry_top.f

./obj_dir/Vretry_tb > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
echo "Simulation passed"
